// File: vdp_timing_pkg.sv
// --------------------------------------------------
// Fixed video timing constants of the display core
// Horizontal border, TV offsets, blanking start lines
// Base top line and field end half-line counts
// --------------------------------------------------

package vdp_timing_pkg;

    // Horizontal count where the active area starts
    localparam logic [10:0] LEFT_BORDER = 11'd235;

    // Lines hidden above the picture on a TV set
    localparam logic [4:0] LED_TV_Y_NTSC = 5'd3;
    localparam logic [4:0] LED_TV_Y_PAL  = 5'd6;

    // First blanked line after the picture
    // NTSC variants
    localparam logic [8:0] V_BLANKING_START_192_NTSC = 9'd240;
    localparam logic [8:0] V_BLANKING_START_212_NTSC = 9'd250;
    // PAL variants, longer field
    localparam logic [8:0] V_BLANKING_START_192_PAL  = 9'd263;
    localparam logic [8:0] V_BLANKING_START_212_PAL  = 9'd273;

    // Top line of the picture before the R#18 adjust
    localparam logic [6:0] OFFSET_Y_BASE = 7'd10;

    // Last half-line count of one field
    // Non-interlaced NTSC, 262 lines
    localparam logic [9:0] FIELD_END_NTSC    = 10'd523;
    // Interlaced NTSC, 262.5 lines
    localparam logic [9:0] FIELD_END_NTSC_IL = 10'd524;
    // Non-interlaced PAL, 313 lines
    localparam logic [9:0] FIELD_END_PAL     = 10'd625;
    // Interlaced PAL, 312.5 lines
    localparam logic [9:0] FIELD_END_PAL_IL  = 10'd624;

endpackage

// File: vdp_ctrl_pkg.sv
// --------------------------------------------------
// Control port and register types
// Second port byte union, display mode struct
// Interrupt control and status structs
// --------------------------------------------------

package vdp_ctrl_pkg;

    // Second byte read as a register write
    typedef struct packed {
        logic       reg_flag;
        logic       spare;
        logic [5:0] reg_num;
    } vdp_port_reg_t;

    // Second byte read as a VRAM address set
    typedef struct packed {
        logic       reg_flag;
        logic       write_flag;
        logic [5:0] addr_hi;
    } vdp_port_addr_t;

    // Same 8 bits, two decodings
    // Bit 7 selects which view applies
    typedef union packed {
        vdp_port_reg_t  regw;
        vdp_port_addr_t addr;
    } vdp_port_byte_u;

    // Display mode from R#9 and R#18
    typedef struct packed {
        logic       pal_mode;
        logic       interlace_mode;
        logic       y212_mode;
        // Top line of the picture
        logic [6:0] offset_y;
    } vdp_mode_t;

    // Interrupt enables and line compare value
    typedef struct packed {
        // Vertical blank interrupt enable, R#1
        logic       ie0;
        // Line interrupt enable, R#0
        logic       ie1;
        logic [7:0] int_line;
    } vdp_int_ctrl_t;

    // Interrupt flags seen by the host
    typedef struct packed {
        logic f;
        logic fh;
    } vdp_status_t;

endpackage

// File: vdp_port_ctrl.sv
// --------------------------------------------------
// Host control port with credit-based byte buffer
// Byte-pair decoding into register writes
// Mode and interrupt registers, VRAM address latch
// --------------------------------------------------
`timescale 1ns/10ps

module vdp_port_ctrl
    import vdp_timing_pkg::*;
    import vdp_ctrl_pkg::*;
#(
    parameter int CREDITS = 4
) (
    input  logic          CLK21M,
    input  logic          RESET,
    input  logic          port_valid,
    input  logic [7:0]    port_data,
    output logic          credit_return,
    output vdp_mode_t     mode,
    output vdp_int_ctrl_t int_ctrl,
    output logic [13:0]   vram_addr
);

    localparam int PTR_W = (CREDITS > 1) ? $clog2(CREDITS) : 1;
    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [7:0]       buf_mem [CREDITS];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             pop;
    vdp_port_byte_u   head;
    logic             second_byte;
    logic [7:0]       data_latch;
    logic             reg_ie0;
    logic             reg_ie1;
    logic             reg_pal;
    logic             reg_interlace;
    logic             reg_y212;
    logic [3:0]       reg_adjust_y;
    logic [7:0]       reg_int_line;

    // Circular pointer step, wraps at the buffer depth
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(CREDITS - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Drain one byte per cycle while anything is held
    assign pop  = (count != '0);
    assign head = buf_mem[rd_ptr];

    // Byte storage
    always_ff @(posedge CLK21M) begin
        if (port_valid) begin
            buf_mem[wr_ptr] <= port_data;
        end
    end

    // Pointers, fill level and credit pulse
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (port_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({port_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back for each byte taken out
            credit_return <= pop;
        end
    end

    // First byte of a pair is plain data
    always_ff @(posedge CLK21M) begin
        if (pop && !second_byte) begin
            data_latch <= head;
        end
    end

    // Pair toggle and second byte decode
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            second_byte   <= 1'b0;
            reg_ie0       <= 1'b0;
            reg_ie1       <= 1'b0;
            reg_pal       <= 1'b0;
            reg_interlace <= 1'b0;
            reg_y212      <= 1'b0;
            reg_adjust_y  <= '0;
            reg_int_line  <= '0;
            vram_addr     <= '0;
        end else if (pop) begin
            second_byte <= ~second_byte;
            if (second_byte) begin
                if (head.regw.reg_flag) begin
                    // Register write, unlisted numbers dropped
                    case (head.regw.reg_num)
                        6'd0: reg_ie1 <= data_latch[4];
                        6'd1: reg_ie0 <= data_latch[5];
                        6'd9: begin
                            reg_y212      <= data_latch[7];
                            reg_interlace <= data_latch[3];
                            reg_pal       <= data_latch[1];
                        end
                        6'd18: reg_adjust_y <= data_latch[7:4];
                        6'd19: reg_int_line <= data_latch;
                        default: ;
                    endcase
                end else begin
                    // Address set, upper 6 over lower 8
                    vram_addr <= {head.addr.addr_hi, data_latch};
                end
            end
        end
    end

    // Mode word to the counter
    assign mode.pal_mode       = reg_pal;
    assign mode.interlace_mode = reg_interlace;
    assign mode.y212_mode      = reg_y212;
    // Adjust nibble is signed, -8 to +7 lines
    assign mode.offset_y = OFFSET_Y_BASE + {{3{reg_adjust_y[3]}}, reg_adjust_y};

    // Interrupt control word
    assign int_ctrl.ie0      = reg_ie0;
    assign int_ctrl.ie1      = reg_ie1;
    assign int_ctrl.int_line = reg_int_line;

endmodule

// File: vdp_hvcounter.sv
// --------------------------------------------------
// Horizontal and vertical counters
// Field id, frame counter, mode resync at frame end
// Horizontal and vertical blanking flags
// --------------------------------------------------
`timescale 1ns/10ps

module vdp_hvcounter
    import vdp_timing_pkg::*;
    import vdp_ctrl_pkg::*;
#(
    parameter logic [10:0] CLOCKS_PER_LINE = 11'd1368
) (
    input  logic        CLK21M,
    input  logic        RESET,
    input  vdp_mode_t   mode,
    output logic [10:0] h_cnt,
    output logic [9:0]  v_cnt_in_field,
    output logic [10:0] v_cnt_in_frame,
    output logic        field,
    output logic        h_blank,
    output logic        v_blank
);

    localparam logic [10:0] H_HALF = CLOCKS_PER_LINE / 2 - 11'd1;
    localparam logic [10:0] H_LAST = CLOCKS_PER_LINE - 11'd1;

    logic       ff_pal_mode;
    logic       ff_interlace_mode;
    logic       half_step;
    logic       h_end;
    logic       h_border;
    logic [9:0] field_end_cnt;
    logic       field_end;
    logic       frame_end;
    logic [4:0] tv_y;
    logic [8:0] vbl_start_line;
    logic       il_odd;
    logic       vbl_start;
    logic       vbl_end;

    // Line end and mid-line strobes
    assign h_end     = (h_cnt == H_LAST);
    assign half_step = (h_cnt == H_HALF) || h_end;
    assign h_border  = (h_cnt == LEFT_BORDER);

    // Horizontal position, wraps each line
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            h_cnt <= '0;
        end else if (h_end) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // Field length from the resynced mode
    always_comb begin
        case ({ff_interlace_mode, ff_pal_mode})
            2'b00: field_end_cnt = FIELD_END_NTSC;
            2'b10: field_end_cnt = FIELD_END_NTSC_IL;
            2'b01: field_end_cnt = FIELD_END_PAL;
            2'b11: field_end_cnt = FIELD_END_PAL_IL;
        endcase
    end

    assign field_end = (v_cnt_in_field == field_end_cnt);
    // Odd field ending closes the frame
    assign frame_end = field_end && field;

    // PAL and interlace only switch between frames
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            ff_pal_mode       <= 1'b0;
            ff_interlace_mode <= 1'b0;
        end else if (half_step && frame_end) begin
            ff_pal_mode       <= mode.pal_mode;
            ff_interlace_mode <= mode.interlace_mode;
        end
    end

    // Half-line count in the field, field toggle, half-line count in the frame
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            v_cnt_in_field <= '0;
            v_cnt_in_frame <= '0;
            field          <= 1'b0;
        end else if (half_step) begin
            if (field_end) begin
                v_cnt_in_field <= '0;
                field          <= ~field;
            end else begin
                v_cnt_in_field <= v_cnt_in_field + 1'b1;
            end
            if (frame_end) begin
                v_cnt_in_frame <= '0;
            end else begin
                v_cnt_in_frame <= v_cnt_in_frame + 1'b1;
            end
        end
    end

    // Horizontal blanking from line end to the left border
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            h_blank <= 1'b0;
        end else if (h_end) begin
            h_blank <= 1'b1;
        end else if (h_border) begin
            h_blank <= 1'b0;
        end
    end

    // Blank start line by height and standard
    // y212 acts at once, PAL only after resync
    always_comb begin
        case ({mode.y212_mode, ff_pal_mode})
            2'b00: vbl_start_line = V_BLANKING_START_192_NTSC;
            2'b10: vbl_start_line = V_BLANKING_START_212_NTSC;
            2'b01: vbl_start_line = V_BLANKING_START_192_PAL;
            2'b11: vbl_start_line = V_BLANKING_START_212_PAL;
        endcase
    end

    assign tv_y   = ff_pal_mode ? LED_TV_Y_PAL : LED_TV_Y_NTSC;
    // Odd interlaced field runs half a line late
    assign il_odd = field & ff_interlace_mode;

    // Compare in half lines, line number shifted up one
    assign vbl_start = (v_cnt_in_field == {vbl_start_line + {4'd0, tv_y}, il_odd});
    assign vbl_end   = (v_cnt_in_field == {2'b00, mode.offset_y + {2'b00, tv_y}, il_odd});

    // Vertical blanking flips only at the left border
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            v_blank <= 1'b0;
        end else if (h_border) begin
            if (vbl_end) begin
                v_blank <= 1'b0;
            end else if (vbl_start) begin
                v_blank <= 1'b1;
            end
        end
    end

endmodule

// File: vdp_interrupt.sv
// --------------------------------------------------
// Vertical blank and line interrupt flags
// Status read clear, registered active-low request
// --------------------------------------------------
`timescale 1ns/10ps

module vdp_interrupt
    import vdp_timing_pkg::*;
    import vdp_ctrl_pkg::*;
(
    input  logic          CLK21M,
    input  logic          RESET,
    input  vdp_int_ctrl_t int_ctrl,
    input  logic [10:0]   h_cnt,
    input  logic [9:0]    v_cnt_in_field,
    input  logic          v_blank,
    input  logic          status_rd,
    output vdp_status_t   status,
    output logic          int_n
);

    logic v_blank_d;
    logic vbl_rise;
    logic line_match;
    logic f_flag;
    logic fh_flag;

    // Previous blanking level for edge detect
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            v_blank_d <= 1'b0;
        end else begin
            v_blank_d <= v_blank;
        end
    end

    assign vbl_rise = v_blank & ~v_blank_d;

    // Whole line number is the half-line count over two
    assign line_match = (h_cnt == LEFT_BORDER) &&
                        (v_cnt_in_field[9:1] == {1'b0, int_ctrl.int_line});

    // Flags, a new event beats a same-cycle read
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            f_flag  <= 1'b0;
            fh_flag <= 1'b0;
        end else begin
            if (vbl_rise) begin
                f_flag <= 1'b1;
            end else if (status_rd) begin
                f_flag <= 1'b0;
            end
            if (line_match) begin
                fh_flag <= 1'b1;
            end else if (status_rd) begin
                fh_flag <= 1'b0;
            end
        end
    end

    assign status.f  = f_flag;
    assign status.fh = fh_flag;

    // Request to the CPU, masked by the enables
    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            int_n <= 1'b1;
        end else begin
            int_n <= ~((f_flag & int_ctrl.ie0) | (fh_flag & int_ctrl.ie1));
        end
    end

endmodule

// File: vdp_top.sv
// --------------------------------------------------
// Display timing core top level
// Port controller, counters and interrupt block
// --------------------------------------------------
`timescale 1ns/10ps

module vdp_top
    import vdp_ctrl_pkg::*;
#(
    parameter int          CREDITS         = 4,
    parameter logic [10:0] CLOCKS_PER_LINE = 11'd1368
) (
    input  logic        CLK21M,
    input  logic        RESET,
    input  logic        port_valid,
    input  logic [7:0]  port_data,
    input  logic        status_rd,
    output logic        credit_return,
    output logic [13:0] vram_addr,
    output logic [10:0] h_cnt,
    output logic [9:0]  v_cnt_in_field,
    output logic [10:0] v_cnt_in_frame,
    output logic        field,
    output logic        h_blank,
    output logic        v_blank,
    output vdp_status_t status,
    output logic        int_n
);

    // Decoded register state
    vdp_mode_t     mode;
    vdp_int_ctrl_t int_ctrl;

    // Host bytes in, modes and enables out
    vdp_port_ctrl #(
        .CREDITS(CREDITS)
    ) port_ctrl_inst (
        .CLK21M       (CLK21M),
        .RESET        (RESET),
        .port_valid   (port_valid),
        .port_data    (port_data),
        .credit_return(credit_return),
        .mode         (mode),
        .int_ctrl     (int_ctrl),
        .vram_addr    (vram_addr)
    );

    // Raster position and blanking
    vdp_hvcounter #(
        .CLOCKS_PER_LINE(CLOCKS_PER_LINE)
    ) hvcounter_inst (
        .CLK21M        (CLK21M),
        .RESET         (RESET),
        .mode          (mode),
        .h_cnt         (h_cnt),
        .v_cnt_in_field(v_cnt_in_field),
        .v_cnt_in_frame(v_cnt_in_frame),
        .field         (field),
        .h_blank       (h_blank),
        .v_blank       (v_blank)
    );

    // Interrupt flags from raster events
    vdp_interrupt interrupt_inst (
        .CLK21M        (CLK21M),
        .RESET         (RESET),
        .int_ctrl      (int_ctrl),
        .h_cnt         (h_cnt),
        .v_cnt_in_field(v_cnt_in_field),
        .v_blank       (v_blank),
        .status_rd     (status_rd),
        .status        (status),
        .int_n         (int_n)
    );

endmodule

// File: vdp_assertions.sv
// --------------------------------------------------
// Bound checks on the display timing core
// Host credit limit, horizontal range, blanking edge
// --------------------------------------------------
`timescale 1ns/10ps

module vdp_assertions
    import vdp_timing_pkg::*;
#(
    parameter int          CREDITS         = 4,
    parameter logic [10:0] CLOCKS_PER_LINE = 11'd1368
) (
    input logic        CLK21M,
    input logic        RESET,
    input logic        port_valid,
    input logic        credit_return,
    input logic [10:0] h_cnt,
    input logic        v_blank
);

    // Bytes sent and not yet credited back
    int outstanding;

    always_ff @(posedge CLK21M or posedge RESET) begin
        if (RESET) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(port_valid) - int'(credit_return);
        end
    end

    // Host never holds more bytes in flight than the buffer depth
    credit_limit: assert property (@(posedge CLK21M) disable iff (RESET)
        outstanding <= CREDITS)
        else $error("host bytes in flight exceed the buffer depth");

    // Horizontal count wraps before the line length
    h_cnt_range: assert property (@(posedge CLK21M) disable iff (RESET)
        h_cnt < CLOCKS_PER_LINE)
        else $error("h_cnt out of range");

    // Vertical blanking moves only at the left border
    v_blank_edge: assert property (@(posedge CLK21M) disable iff (RESET)
        (v_blank != $past(v_blank)) |-> ($past(h_cnt) == LEFT_BORDER))
        else $error("v_blank changed away from the left border");

endmodule

bind vdp_top vdp_assertions #(
    .CREDITS        (CREDITS),
    .CLOCKS_PER_LINE(CLOCKS_PER_LINE)
) vdp_assertions_inst (
    .CLK21M       (CLK21M),
    .RESET        (RESET),
    .port_valid   (port_valid),
    .credit_return(credit_return),
    .h_cnt        (h_cnt),
    .v_blank      (v_blank)
);

// File: tb_vdp.sv
// --------------------------------------------------
// Testbench for the display timing core
// Clock, reset, LCG, host credit model, check task
// Directed tests for timing, interrupts and port
// --------------------------------------------------
`timescale 1ns/10ps

module tb_vdp
    import vdp_timing_pkg::*;
    import vdp_ctrl_pkg::*;
();

    localparam int CREDITS         = 4;
    localparam int CLOCKS_PER_LINE = 1368;
    localparam int HALF_LINE       = CLOCKS_PER_LINE / 2;
    // Wait limits in clock cycles
    localparam int EDGE_LIMIT   = 4;
    localparam int CREDIT_LIMIT = 32;
    localparam int LINE_LIMIT   = 2 * CLOCKS_PER_LINE;
    localparam int FIELD_LIMIT  = 700 * HALF_LINE;
    // Single-bit outputs that the wait task can follow
    localparam int SIG_H_BLANK = 0;
    localparam int SIG_V_BLANK = 1;
    localparam int SIG_FIELD   = 2;
    localparam int SIG_INT_N   = 3;
    localparam int SIG_FLAG_F  = 4;
    localparam int SIG_FLAG_FH = 5;

    logic        CLK21M = 1'b0;
    logic        RESET;
    logic        port_valid;
    logic [7:0]  port_data;
    logic        status_rd;
    logic        credit_return;
    logic [13:0] vram_addr;
    logic [10:0] h_cnt;
    logic [9:0]  v_cnt_in_field;
    logic [10:0] v_cnt_in_frame;
    logic        field;
    logic        h_blank;
    logic        v_blank;
    vdp_status_t status;
    logic        int_n;

    int          errors;
    int          checks;
    // Host side credit count and returned pulses
    int          credits;
    int          returned;
    logic [31:0] lcg_state = 32'd83130;

    vdp_top vdp_top_inst (
        .CLK21M        (CLK21M),
        .RESET         (RESET),
        .port_valid    (port_valid),
        .port_data     (port_data),
        .status_rd     (status_rd),
        .credit_return (credit_return),
        .vram_addr     (vram_addr),
        .h_cnt         (h_cnt),
        .v_cnt_in_field(v_cnt_in_field),
        .v_cnt_in_frame(v_cnt_in_frame),
        .field         (field),
        .h_blank       (h_blank),
        .v_blank       (v_blank),
        .status        (status),
        .int_n         (int_n)
    );

    // 8 ns clock
    initial begin
        forever #4 CLK21M = ~CLK21M;
    end

    // Credit pulses seen at the rising edge
    always @(posedge CLK21M) begin
        if (credit_return) begin
            credits  = credits + 1;
            returned = returned + 1;
        end
    end

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    function automatic logic probe(input int sel);
        case (sel)
            SIG_H_BLANK: return h_blank;
            SIG_V_BLANK: return v_blank;
            SIG_FIELD:   return field;
            SIG_INT_N:   return int_n;
            SIG_FLAG_F:  return status.f;
            SIG_FLAG_FH: return status.fh;
            default:     return 1'b0;
        endcase
    endfunction

    function automatic string probe_name(input int sel);
        case (sel)
            SIG_H_BLANK: return "h_blank";
            SIG_V_BLANK: return "v_blank";
            SIG_FIELD:   return "field";
            SIG_INT_N:   return "int_n";
            SIG_FLAG_F:  return "status.f";
            SIG_FLAG_FH: return "status.fh";
            default:     return "unknown";
        endcase
    endfunction

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    // Steps falling edges until the output reaches the level
    task automatic wait_value(input int sel, input logic value, input int limit,
                              output int cycles);
        cycles = 0;
        while (probe(sel) !== value && cycles < limit) begin
            @(negedge CLK21M);
            cycles++;
        end
        if (probe(sel) !== value) begin
            errors++;
            $display("Timeout: %s did not reach %0d within %0d cycles",
                     probe_name(sel), value, limit);
        end
    endtask

    task automatic apply_reset();
        RESET      = 1'b1;
        port_valid = 1'b0;
        port_data  = 8'h00;
        status_rd  = 1'b0;
        repeat (5) @(negedge CLK21M);
        RESET    = 1'b0;
        credits  = CREDITS;
        returned = 0;
    endtask

    // One byte into the port, spends a credit
    task automatic port_write(input logic [7:0] value);
        int n;
        n = 0;
        while (credits == 0 && n < CREDIT_LIMIT) begin
            @(negedge CLK21M);
            n++;
        end
        if (credits == 0) begin
            errors++;
            $display("Timeout: no credit came back for a port write");
        end else begin
            credits    = credits - 1;
            port_valid = 1'b1;
            port_data  = value;
            @(negedge CLK21M);
            port_valid = 1'b0;
        end
    endtask

    // Data byte then register number with the flag set
    task automatic write_reg(input int num, input logic [7:0] value);
        port_write(value);
        port_write(8'h80 | 8'(num));
    endtask

    task automatic wait_credits_home();
        int n;
        n = 0;
        while (credits != CREDITS && n < CREDIT_LIMIT) begin
            @(negedge CLK21M);
            n++;
        end
        if (credits != CREDITS) begin
            errors++;
            $display("Timeout: host credits did not all come back");
        end
    endtask

    task automatic pulse_status_read();
        status_rd = 1'b1;
        @(negedge CLK21M);
        status_rd = 1'b0;
    endtask

    task automatic test_line_timing();
        int n_high;
        int n_low;
        wait_value(SIG_H_BLANK, 1'b1, LINE_LIMIT, n_low);
        wait_value(SIG_H_BLANK, 1'b0, LINE_LIMIT, n_high);
        check_equal("h_blank high cycles", n_high, LEFT_BORDER + 1);
        wait_value(SIG_H_BLANK, 1'b1, LINE_LIMIT, n_low);
        check_equal("h_blank period", n_high + n_low, CLOCKS_PER_LINE);
    endtask

    task automatic test_field_lengths();
        int n;
        wait_value(SIG_FIELD, 1'b1, FIELD_LIMIT, n);
        wait_value(SIG_FIELD, 1'b0, FIELD_LIMIT, n);
        check_equal("NTSC field cycles", n, 524 * HALF_LINE);
        check_equal("v_cnt_in_frame", v_cnt_in_frame, 0);
        // PAL requested in the even field
        write_reg(9, 8'h02);
        wait_value(SIG_FIELD, 1'b1, FIELD_LIMIT, n);
        wait_value(SIG_FIELD, 1'b0, FIELD_LIMIT, n);
        // Odd field still runs at NTSC length
        check_equal("odd field before resync", n, 524 * HALF_LINE);
        check_equal("v_cnt_in_frame", v_cnt_in_frame, 0);
        wait_value(SIG_FIELD, 1'b1, FIELD_LIMIT, n);
        check_equal("PAL even field cycles", n, 626 * HALF_LINE);
        wait_value(SIG_FIELD, 1'b0, FIELD_LIMIT, n);
        check_equal("PAL odd field cycles", n, 626 * HALF_LINE);
        check_equal("v_cnt_in_frame", v_cnt_in_frame, 0);
    endtask

    task automatic test_vblank_lines();
        int n;
        int adj;
        adj = -2;
        wait_value(SIG_V_BLANK, 1'b1, FIELD_LIMIT, n);
        check_equal("v_cnt_in_field at blank start", v_cnt_in_field,
                    2 * (int'(V_BLANKING_START_192_NTSC) + int'(LED_TV_Y_NTSC)));
        check_equal("h_cnt at blank start", h_cnt, LEFT_BORDER + 1);
        wait_value(SIG_V_BLANK, 1'b0, FIELD_LIMIT, n);
        check_equal("v_cnt_in_field at blank end", v_cnt_in_field,
                    2 * (int'(OFFSET_Y_BASE) + int'(LED_TV_Y_NTSC)));
        // Adjust -2 lines, then 212 lines
        write_reg(18, 8'hE0);
        write_reg(9, 8'h80);
        wait_value(SIG_V_BLANK, 1'b1, FIELD_LIMIT, n);
        check_equal("v_cnt_in_field at 212 blank start", v_cnt_in_field,
                    2 * (int'(V_BLANKING_START_212_NTSC) + int'(LED_TV_Y_NTSC)));
        wait_value(SIG_V_BLANK, 1'b0, FIELD_LIMIT, n);
        check_equal("v_cnt_in_field at adjusted blank end", v_cnt_in_field,
                    2 * (int'(OFFSET_Y_BASE) + adj + int'(LED_TV_Y_NTSC)));
    endtask

    task automatic test_vertical_interrupt();
        int n;
        write_reg(1, 8'h20);
        check_equal("int_n before blank", int_n, 1);
        wait_value(SIG_V_BLANK, 1'b1, FIELD_LIMIT, n);
        wait_value(SIG_FLAG_F, 1'b1, EDGE_LIMIT, n);
        check_equal("status.f delay", n, 1);
        wait_value(SIG_INT_N, 1'b0, EDGE_LIMIT, n);
        check_equal("int_n delay", n, 1);
        pulse_status_read();
        wait_value(SIG_INT_N, 1'b1, EDGE_LIMIT, n);
        check_equal("status.f after read", status.f, 0);
    endtask

    task automatic test_line_interrupt();
        int n;
        int line;
        line = 100;
        write_reg(0, 8'h10);
        write_reg(19, 8'(line));
        wait_value(SIG_FLAG_FH, 1'b1, FIELD_LIMIT, n);
        check_equal("line at status.fh", v_cnt_in_field[9:1], line);
        check_equal("h_cnt at status.fh", h_cnt, LEFT_BORDER + 1);
        wait_value(SIG_INT_N, 1'b0, EDGE_LIMIT, n);
        pulse_status_read();
        wait_value(SIG_INT_N, 1'b1, EDGE_LIMIT, n);
        check_equal("status.fh after read", status.fh, 0);
        // Flag without the enable
        line = 150;
        write_reg(0, 8'h00);
        write_reg(19, 8'(line));
        wait_value(SIG_FLAG_FH, 1'b1, FIELD_LIMIT, n);
        check_equal("line at masked status.fh", v_cnt_in_field[9:1], line);
        repeat (EDGE_LIMIT) begin
            @(negedge CLK21M);
            check_equal("int_n masked", int_n, 1);
        end
    endtask

    task automatic test_address_burst();
        logic [7:0]  lo;
        logic [7:0]  hi;
        logic [13:0] exp_addr;
        int          regn;
        int          sent;
        int          round;
        int          p;
        sent     = 0;
        exp_addr = '0;
        for (round = 0; round < 3; round++) begin
            for (p = 0; p < CREDITS / 2; p++) begin
                if (p == CREDITS / 2 - 1) begin
                    // Address pair closes the burst
                    lo       = rand_byte();
                    hi       = rand_byte() & 8'h7F;
                    exp_addr = {hi[5:0], lo};
                    port_write(lo);
                    port_write(hi);
                end else begin
                    // Random data into an unused register, R#2 to R#8
                    regn = 2 + int'(rand_byte()) % 7;
                    port_write(rand_byte());
                    port_write(8'h80 | 8'(regn));
                end
                sent += 2;
            end
            wait_credits_home();
            check_equal("vram_addr", vram_addr, exp_addr);
        end
        check_equal("credit_return pulses", returned, sent);
    endtask

    initial begin
        RESET      = 1'b1;
        port_valid = 1'b0;
        port_data  = 8'h00;
        status_rd  = 1'b0;
        errors     = 0;
        checks     = 0;
        credits    = CREDITS;
        returned   = 0;
        apply_reset();
        test_line_timing();
        apply_reset();
        test_field_lengths();
        apply_reset();
        test_vblank_lines();
        apply_reset();
        test_vertical_interrupt();
        apply_reset();
        test_line_interrupt();
        apply_reset();
        test_address_burst();
        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: verilog.f
vdp_timing_pkg.sv
vdp_ctrl_pkg.sv
vdp_port_ctrl.sv
vdp_hvcounter.sv
vdp_interrupt.sv
vdp_top.sv
vdp_assertions.sv
tb_vdp.sv

// File: Bender.yml
package:
  name: vdp_timing_core

sources:
  # Packages first, then the design
  - vdp_timing_pkg.sv
  - vdp_ctrl_pkg.sv
  - vdp_port_ctrl.sv
  - vdp_hvcounter.sv
  - vdp_interrupt.sv
  - vdp_top.sv
  # Simulation only
  - target: test
    files:
      - vdp_assertions.sv
      - tb_vdp.sv
